// File: Bender.yml
package:
  name: pattern_src

sources:
  - include_dirs:
      - hw
    files:
      - hw/pattern_mode_pkg.sv
      - hw/tx_word_pkg.sv
      - hw/frame_sequencer.sv
      - hw/ctrl_block_gen.sv
      - hw/payload_gen.sv
      - hw/tx_lane_mux.sv
      - hw/pattern_src_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/pattern_src_asserts.sv
      - verification/pattern_src_tb.sv

// File: hw/ctrl_block_gen.sv
// Control word generator.
// Turns the current slot into the ordered set for 8b10b frames
// (alignment, idle or GE-style skip) with matching K flags, or into
// the sync-header code for 64b66b blocks. Purely combinational.

`timescale 1ns/1ps

`include "pattern_src_cfg.svh"

module ctrl_block_gen (
    input  pattern_mode_pkg::slot_t    i_slot,
    output tx_word_pkg::ctrl_word_t    o_ctrl
);

    import pattern_mode_pkg::*;
    import tx_word_pkg::*;

    localparam code_char_t C_K28_5 = `K28_5;
    localparam code_char_t C_K28_3 = `K28_3;
    localparam code_char_t C_D5_6  = `D5_6;
    localparam code_char_t C_D16_2 = `D16_2;

    // c0 goes out first, in byte 0
    function automatic ctrl_word_t pack_chars(
        input code_char_t c0,
        input code_char_t c1,
        input code_char_t c2,
        input code_char_t c3
    );
        ctrl_word_t w;
        w.word.bytes = {c3.data, c2.data, c1.data, c0.data};
        w.k          = {c3.k, c2.k, c1.k, c0.k};
        w.hdr        = 3'b000;
        return w;
    endfunction

    always_comb begin
        o_ctrl = '0;
        case (i_slot.kind)
            SLOT_ALIGN: begin
                o_ctrl = pack_chars(C_K28_3, C_D5_6, C_K28_5, C_D5_6);
            end
            SLOT_IDLE: begin
                o_ctrl = pack_chars(C_K28_5, C_D5_6, C_K28_5, C_D5_6);
            end
            SLOT_SKIP: begin
                o_ctrl = pack_chars(C_K28_5, C_D16_2, C_K28_5, C_D16_2);
            end
            SLOT_BLOCK: begin
                // Data comes from the payload side
                o_ctrl.word.block = 32'h0;
                o_ctrl.k          = 4'h0;
                o_ctrl.hdr        = `HDR_66B;
            end
            default: begin
                o_ctrl = '0;
            end
        endcase
    end

endmodule

// File: hw/frame_sequencer.sv
// Frame sequencer for the pattern source.
// Holds the active line-code mode and steps through the slots of the
// frame, one slot per clock. A mode-load strobe takes the new mode
// and starts a fresh frame at slot 0.

`timescale 1ns/1ps

`include "pattern_src_cfg.svh"

module frame_sequencer (
    input  logic                    src_clk,
    input  logic                    i_src_rstn,
    input  logic                    i_mode_load,
    input  pattern_mode_pkg::mode_e i_mode,
    output pattern_mode_pkg::slot_t o_slot
);

    import pattern_mode_pkg::*;

    mode_e      mode_q;
    logic [6:0] index_q;
    logic       restart_q;
    logic [6:0] last_index;
    slot_kind_e kind;

    assign last_index = (mode_q == MODE_66B) ? `SEQ_LEN_66B - 7'd1 : `SEQ_LEN_8B10B - 7'd1;

    always_ff @(posedge src_clk) begin
        if (!i_src_rstn) begin
            mode_q    <= MODE_8B10B;
            index_q   <= '0;
            restart_q <= 1'b1;
        end else if (i_mode_load) begin
            mode_q    <= i_mode;
            index_q   <= '0;
            restart_q <= 1'b1;
        end else begin
            index_q   <= (index_q == last_index) ? 7'd0 : index_q + 7'd1;
            restart_q <= 1'b0;
        end
    end

    ////////////////////
    // Slot kind
    ////////////////////

    always_comb begin
        kind = SLOT_ALIGN;
        if (mode_q == MODE_66B) begin
            kind = SLOT_BLOCK;
        end else if (index_q inside {[`IDLE_FIRST:`IDLE_LAST]}) begin
            kind = SLOT_IDLE;
        end else if (index_q == `SKIP_SLOT) begin
            kind = SLOT_SKIP;
        end else if (index_q == `PAYLOAD_SLOT_8B10B) begin
            kind = SLOT_PAYLOAD;
        end
    end

    assign o_slot.mode    = mode_q;
    assign o_slot.kind    = kind;
    assign o_slot.index   = index_q;
    assign o_slot.restart = restart_q;

endmodule

// File: hw/pattern_mode_pkg.sv
// Types that describe the frame structure of the pattern source.
// The sequencer fills a slot record each cycle and the generators
// and the lane mux decode it.

package pattern_mode_pkg;

    // Line code in use
    typedef enum logic {
        MODE_8B10B = 1'b0,
        MODE_66B   = 1'b1
    } mode_e;

    // What the current slot carries
    typedef enum logic [2:0] {
        SLOT_ALIGN   = 3'd0,
        SLOT_IDLE    = 3'd1,
        SLOT_SKIP    = 3'd2,
        SLOT_PAYLOAD = 3'd3,
        SLOT_BLOCK   = 3'd4
    } slot_kind_e;

    // Restart marks the first slot of a run, after reset or a mode load
    typedef struct packed {
        mode_e      mode;
        slot_kind_e kind;
        logic [6:0] index;
        logic       restart;
    } slot_t;

endpackage

// File: hw/pattern_src_cfg.svh
// Constants for the transmit test-pattern source.
// Frame lengths and slot positions follow the line codes, the code
// characters carry the K flag in bit 8.
// Include in any RTL file that needs one of these values.

`ifndef PATTERN_SRC_CFG_SVH
`define PATTERN_SRC_CFG_SVH

////////////////////
// Frame lengths
////////////////////

`define SEQ_LEN_8B10B       7'd8
`define SEQ_LEN_66B         7'd33

////////////////////
// 8b10b slot map
////////////////////

`define IDLE_FIRST          7'd1
`define IDLE_LAST           7'd5
`define SKIP_SLOT           7'd6
`define PAYLOAD_SLOT_8B10B  7'd7

// Only block word that carries zeros
`define ZERO_SLOT_66B       7'd31

////////////////////
// Code characters
////////////////////

`define K28_5               9'h1BC
`define K28_3               9'h17C
`define D5_6                9'h0C5
`define D16_2               9'h050

////////////////////
// Payload seeds
////////////////////

`define WALK_SEED           32'h0000_0001
`define BLOCK_FILL          32'hAAAA_AAAA
`define HDR_66B             3'b001

`endif

// File: hw/pattern_src_top.sv
// Top level of the transmit test-pattern source for one lane.
// The sequencer feeds the control and payload generators side by side
// and the lane mux merges and registers their words.
// i_mode is sampled only while the single-cycle i_mode_load is high.

`timescale 1ns/1ps

module pattern_src_top (
    input  logic                    src_clk,
    input  logic                    i_src_rstn,
    input  logic                    i_mode_load,
    input  pattern_mode_pkg::mode_e i_mode,
    output tx_word_pkg::tx_lane_t   o_lane
);

    import pattern_mode_pkg::*;
    import tx_word_pkg::*;

    slot_t      slot;
    ctrl_word_t ctrl;
    tx_word_u   payload;

    frame_sequencer u_frame_sequencer (
        .src_clk     (src_clk),
        .i_src_rstn  (i_src_rstn),
        .i_mode_load (i_mode_load),
        .i_mode      (i_mode),
        .o_slot      (slot)
    );

    ////////////////////
    // Generators
    ////////////////////

    ctrl_block_gen u_ctrl_block_gen (
        .i_slot (slot),
        .o_ctrl (ctrl)
    );

    payload_gen u_payload_gen (
        .src_clk    (src_clk),
        .i_src_rstn (i_src_rstn),
        .i_slot     (slot),
        .o_payload  (payload)
    );

    tx_lane_mux u_tx_lane_mux (
        .src_clk    (src_clk),
        .i_src_rstn (i_src_rstn),
        .i_slot     (slot),
        .i_ctrl     (ctrl),
        .i_payload  (payload),
        .o_lane     (o_lane)
    );

endmodule

// File: hw/payload_gen.sv
// Payload generator.
// In 8b10b mode a walking one that moves left after every payload
// slot and starts over on each new run. In 64b66b mode the constant
// AA fill, with one all-zero word per frame.

`timescale 1ns/1ps

`include "pattern_src_cfg.svh"

module payload_gen (
    input  logic                    src_clk,
    input  logic                    i_src_rstn,
    input  pattern_mode_pkg::slot_t i_slot,
    output tx_word_pkg::tx_word_u   o_payload
);

    import pattern_mode_pkg::*;

    logic [31:0] walk_q;

    ////////////////////
    // Walking one
    ////////////////////

    always_ff @(posedge src_clk) begin
        if (!i_src_rstn) begin
            walk_q <= `WALK_SEED;
        end else if (i_slot.restart) begin
            walk_q <= `WALK_SEED;
        end else if (i_slot.kind == SLOT_PAYLOAD) begin
            walk_q <= {walk_q[30:0], walk_q[31]};
        end
    end

    always_comb begin
        if (i_slot.kind == SLOT_BLOCK) begin
            if (i_slot.index == `ZERO_SLOT_66B) begin
                o_payload.block = 32'h0;
            end else begin
                o_payload.block = `BLOCK_FILL;
            end
        end else begin
            o_payload.block = walk_q;
        end
    end

endmodule

// File: hw/tx_lane_mux.sv
// Lane output stage.
// Picks the control or the payload word for the current slot, adds
// the K flags, header and sequence number, and registers the result.
// The lane sees slot n one clock after the sequencer holds it.

`timescale 1ns/1ps

module tx_lane_mux (
    input  logic                       src_clk,
    input  logic                       i_src_rstn,
    input  pattern_mode_pkg::slot_t    i_slot,
    input  tx_word_pkg::ctrl_word_t    i_ctrl,
    input  tx_word_pkg::tx_word_u      i_payload,
    output tx_word_pkg::tx_lane_t      o_lane
);

    import pattern_mode_pkg::*;
    import tx_word_pkg::*;

    tx_lane_t lane_d;
    logic     use_payload;

    assign use_payload = (i_slot.kind == SLOT_PAYLOAD) || (i_slot.kind == SLOT_BLOCK);

    always_comb begin
        lane_d.word = use_payload ? i_payload : i_ctrl.word;
        lane_d.k    = (i_slot.kind == SLOT_PAYLOAD) ? 4'h0 : i_ctrl.k;
        lane_d.hdr  = i_ctrl.hdr;
        // Sequence number only counts blocks
        if (i_slot.mode == MODE_66B) begin
            lane_d.seq = i_slot.index;
        end else begin
            lane_d.seq = 7'd0;
        end
    end

    ////////////////////
    // Output register
    ////////////////////

    always_ff @(posedge src_clk) begin
        if (!i_src_rstn) begin
            o_lane <= '0;
        end else begin
            o_lane <= lane_d;
        end
    end

endmodule

// File: hw/tx_word_pkg.sv
// Types for the words handed to the transceiver lane.
// One 32-bit word is seen as four code characters in 8b10b mode
// and as a single block word in 64b66b mode.

package tx_word_pkg;

    // One 8b10b character before encoding
    typedef struct packed {
        logic       k;
        logic [7:0] data;
    } code_char_t;

    // Byte 0 sits in the lowest bits
    typedef union packed {
        logic [3:0][7:0] bytes;
        logic [31:0]     block;
    } tx_word_u;

    ////////////////////
    // Generator result
    ////////////////////

    typedef struct packed {
        tx_word_u   word;
        logic [3:0] k;
        logic [2:0] hdr;
    } ctrl_word_t;

    ////////////////////
    // Lane output
    ////////////////////

    // K flag bit n belongs to byte n
    typedef struct packed {
        tx_word_u   word;
        logic [3:0] k;
        logic [2:0] hdr;
        logic [6:0] seq;
    } tx_lane_t;

endpackage

// File: tb.f
+incdir+hw
hw/pattern_mode_pkg.sv
hw/tx_word_pkg.sv
hw/frame_sequencer.sv
hw/ctrl_block_gen.sv
hw/payload_gen.sv
hw/tx_lane_mux.sv
hw/pattern_src_top.sv
verification/tb_clk_gen.sv
verification/pattern_src_asserts.sv
verification/pattern_src_tb.sv

// File: verification/pattern_src_asserts.sv
// Protocol checks on the lane output of the pattern source.
// Bound into pattern_src_top, so it watches every instance of it.

`timescale 1ns/1ps

module pattern_src_asserts (
    input logic                  src_clk,
    input logic                  i_src_rstn,
    input tx_word_pkg::tx_lane_t i_lane
);

    import tx_word_pkg::*;

    // Block words never carry control characters
    a_no_k_on_block: assert property (
        @(posedge src_clk) disable iff (!i_src_rstn)
        (i_lane.hdr != 3'b000) |-> (i_lane.k == 4'h0)
    ) else $error("K flags set on a word with a sync header");

    a_hdr_legal: assert property (
        @(posedge src_clk) disable iff (!i_src_rstn)
        (i_lane.hdr == 3'b000) || (i_lane.hdr == 3'b001)
    ) else $error("Sync header holds an illegal code");

    // 33 blocks per frame
    a_seq_range: assert property (
        @(posedge src_clk) disable iff (!i_src_rstn)
        i_lane.seq < 7'd33
    ) else $error("Sequence number beyond the end of the frame");

endmodule

bind pattern_src_top pattern_src_asserts u_asserts (
    .src_clk    (src_clk),
    .i_src_rstn (i_src_rstn),
    .i_lane     (o_lane)
);

// File: verification/pattern_src_patterns.txt
// Ordered sets align, idle, skip: characters for byte 0 to byte 3, K flag in bit 8
// Then steps: mode (0 8b10b, 1 64b66b) and frame count in hex, 1FF ends the list
17C 0C5 1BC 0C5
1BC 0C5 1BC 0C5
1BC 050 1BC 050
0 2
1 2
0 24
1 1
0 1
0 3
1 2
0 2
1FF 0

// File: verification/pattern_src_tb.sv
// Testbench for the transmit pattern source.
// Reads ordered sets and mode-load steps from the pattern file, loads each
// mode at an LCG-chosen point in the frame, and compares every lane word
// with a cycle model of the frame rules.

`timescale 1ns/1ps

module pattern_src_tb;

    import pattern_mode_pkg::*;
    import tx_word_pkg::*;

    localparam int          PAT_DEPTH = 64;
    localparam int          STEP_BASE = 12;
    localparam logic [31:0] FILL_66B  = 32'hAAAA_AAAA;
    localparam logic [2:0]  SYNC_HDR  = 3'b001;

    logic        src_clk;
    logic        i_src_rstn;
    logic        i_mode_load;
    mode_e       i_mode;
    tx_lane_t    o_lane;

    logic [8:0]  pat_mem [0:PAT_DEPTH-1];
    longint      limit_ns;
    logic [31:0] lcg_state;

    // Reference model state, updated once per rising edge
    mode_e       m_mode;
    logic [6:0]  m_index;
    logic        m_restart;
    // Bit position of the walking one
    logic [4:0]  m_walk_pos;

    tb_clk_gen u_clk_gen (
        .o_src_clk  (src_clk),
        .o_src_rstn (i_src_rstn)
    );

    pattern_src_top dut0 (
        .src_clk     (src_clk),
        .i_src_rstn  (i_src_rstn),
        .i_mode_load (i_mode_load),
        .i_mode      (i_mode),
        .o_lane      (o_lane)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int frame_len(input mode_e mode);
        return (mode == MODE_66B) ? 33 : 8;
    endfunction

    // Set 0 align, 1 idle, 2 skip
    function automatic tx_lane_t ordered_set(input int set);
        tx_lane_t l;
        l = '0;
        for (int b = 0; b < 4; b++) begin
            l.word.bytes[b] = pat_mem[set*4 + b][7:0];
            l.k[b]          = pat_mem[set*4 + b][8];
        end
        return l;
    endfunction

    function automatic tx_lane_t expected_lane();
        tx_lane_t l;
        l = '0;
        if (m_mode == MODE_66B) begin
            l.word.block = (m_index == 7'd31) ? 32'h0 : FILL_66B;
            l.hdr        = SYNC_HDR;
            l.seq        = m_index;
        end else if (m_index == 7'd0) begin
            l = ordered_set(0);
        end else if (m_index <= 7'd5) begin
            l = ordered_set(1);
        end else if (m_index == 7'd6) begin
            l = ordered_set(2);
        end else begin
            l.word.block = 32'h1 << m_walk_pos;
        end
        return l;
    endfunction

    task automatic model_edge(input logic rst_seen, input logic load_seen,
                              input mode_e mode_seen, output tx_lane_t exp);
        if (!rst_seen) begin
            exp        = '0;
            m_mode     = MODE_8B10B;
            m_index    = 7'd0;
            m_restart  = 1'b1;
            m_walk_pos = 5'd0;
        end else begin
            exp = expected_lane();
            if (m_restart) begin
                m_walk_pos = 5'd0;
            end else if (m_mode == MODE_8B10B && m_index == 7'd7) begin
                m_walk_pos = m_walk_pos + 5'd1;
            end
            if (load_seen) begin
                m_mode    = mode_seen;
                m_index   = 7'd0;
                m_restart = 1'b1;
            end else begin
                m_index   = (m_index == 7'(frame_len(m_mode) - 1)) ? 7'd0 : m_index + 7'd1;
                m_restart = 1'b0;
            end
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_word(input tx_word_u got, input tx_word_u exp, input string ctx);
        if (got.block !== exp.block) begin
            fail_run($sformatf("Mismatch at %0t: %s word %08h, expected %08h",
                               $time, ctx, got.block, exp.block));
        end
    endtask

    task automatic check_kflags(input logic [3:0] got, input logic [3:0] exp, input string ctx);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s K flags %04b, expected %04b",
                               $time, ctx, got, exp));
        end
    endtask

    task automatic check_hdr_seq(input tx_lane_t got, input tx_lane_t exp, input string ctx);
        if (got.hdr !== exp.hdr || got.seq !== exp.seq) begin
            fail_run($sformatf("Mismatch at %0t: %s header %03b seq %0d, expected %03b seq %0d",
                               $time, ctx, got.hdr, got.seq, exp.hdr, exp.seq));
        end
    endtask

    // Checks the edge that ends this cycle, then drives the next inputs
    task automatic run_cycle(input logic load, input mode_e mode);
        logic     rst_seen;
        logic     load_seen;
        mode_e    mode_seen;
        tx_lane_t exp;
        string    ctx;
        @(posedge src_clk);
        rst_seen  = i_src_rstn;
        load_seen = i_mode_load;
        mode_seen = i_mode;
        ctx       = $sformatf("mode %s slot %0d", m_mode.name(), m_index);
        model_edge(rst_seen, load_seen, mode_seen, exp);
        #1;
        check_word(o_lane.word, exp.word, ctx);
        check_kflags(o_lane.k, exp.k, ctx);
        check_hdr_seq(o_lane, exp, ctx);
        #1;
        i_mode_load = load;
        i_mode      = mode;
    endtask

    initial begin
        int    n_steps;
        int    total;
        int    frames;
        int    offset;
        mode_e step_mode;
        i_mode_load = 1'b0;
        i_mode      = MODE_8B10B;
        lcg_state   = 32'h3f87;
        limit_ns    = 0;
        m_mode      = MODE_8B10B;
        m_index     = 7'd0;
        m_restart   = 1'b1;
        m_walk_pos  = 5'd0;
        $readmemh("verification/pattern_src_patterns.txt", pat_mem);
        n_steps = 0;
        while (STEP_BASE + 2*n_steps + 1 < PAT_DEPTH &&
               pat_mem[STEP_BASE + 2*n_steps] !== 9'h1FF &&
               !$isunknown(pat_mem[STEP_BASE + 2*n_steps])) begin
            n_steps++;
        end
        if (n_steps == 0) begin
            fail_run("Pattern file holds no test steps");
        end
        // Reset, settling run and one spare frame per step
        total = 24;
        for (int i = 0; i < n_steps; i++) begin
            step_mode = mode_e'(pat_mem[STEP_BASE + 2*i][0]);
            total += (pat_mem[STEP_BASE + 2*i + 1] + 1) * frame_len(step_mode) + 1;
        end
        limit_ns = longint'(total + 100) * 40;

        lcg_state = lcg_next(lcg_state);
        repeat (5 + 8 + lcg_state[15:8] % 8) run_cycle(1'b0, MODE_8B10B);

        for (int i = 0; i < n_steps; i++) begin
            step_mode = mode_e'(pat_mem[STEP_BASE + 2*i][0]);
            frames    = pat_mem[STEP_BASE + 2*i + 1];
            lcg_state = lcg_next(lcg_state);
            offset    = lcg_state[15:8] % frame_len(step_mode);
            run_cycle(1'b1, step_mode);
            repeat (frames * frame_len(step_mode) + offset) run_cycle(1'b0, step_mode);
        end
        $display("Simulation PASSED");
        $finish;
    end

    ////////////////////
    // Watchdog
    ////////////////////

    initial begin
        wait (limit_ns > 0);
        #(limit_ns * 1ns);
        fail_run("Watchdog timeout before all test steps finished");
    end

endmodule

// File: verification/tb_clk_gen.sv
// Clock and reset source for the pattern source testbench.
// 40 ns clock, reset held low over the first 4 rising edges and
// released 2 ns after the fourth one.

`timescale 1ns/1ps

module tb_clk_gen (
    output logic o_src_clk,
    output logic o_src_rstn
);

    initial begin
        o_src_clk = 1'b0;
        forever #20 o_src_clk = ~o_src_clk;
    end

    initial begin
        o_src_rstn = 1'b0;
        repeat (4) @(posedge o_src_clk);
        #2;
        o_src_rstn = 1'b1;
    end

endmodule
